/* design/mem_stage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Linear address width.
`define MEM_ADDR_W 16

// Register, memory and immediate value width.
`define MEM_DATA_W 32

// Segment limit width.
`define MEM_LIM_W 16

// Word index width of the local data RAM.
`define MEM_RAM_AW 6

`define MEM_RAM_DEPTH (1 << `MEM_RAM_AW)

`endif

/* design/mem_stage_pkg.sv */
`include "mem_stage_config.svh"

package mem_stage_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] data_t;
    typedef logic [`MEM_LIM_W-1:0]  lim_t;

    // Code n selects an access of 2**n bytes.
    typedef logic [1:0] opsize_t;

    // One-hot or zero. Bit n forces size code n.
    typedef logic [3:0] ovr_t;

    // Access kind. 0 is none, 1 is read, 2 is write.
    typedef logic [1:0] rw_t;

    // Bit 0 flags a segment limit fault, bit 1 comes from earlier stages.
    typedef logic [1:0] exc_t;

    typedef enum logic [1:0] {
        OP_REG   = 2'd0,
        OP_MEM   = 2'd1,
        OP_IMM   = 2'd2,
        OP_ADDR2 = 2'd3
    } op_sel_t;

endpackage

/* design/mem_addr_gen.sv */
`timescale 1ns/100ps

module mem_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_in,
    output logic                   stall,
    input  logic                   s1_ready,
    input  mem_stage_pkg::opsize_t opsize,
    input  mem_stage_pkg::ovr_t    size_ovr,
    input  logic                   is_push,
    input  mem_stage_pkg::addr_t   addr1,
    input  mem_stage_pkg::addr_t   addr2,
    input  mem_stage_pkg::rw_t     rw1,
    input  mem_stage_pkg::rw_t     rw2,
    input  mem_stage_pkg::lim_t    lim1,
    input  mem_stage_pkg::lim_t    lim2,
    input  mem_stage_pkg::data_t   reg1,
    input  mem_stage_pkg::data_t   reg2,
    input  mem_stage_pkg::data_t   imm,
    input  mem_stage_pkg::op_sel_t op1_sel,
    input  mem_stage_pkg::op_sel_t op2_sel,
    input  logic                   ie_in,
    input  mem_stage_pkg::exc_t    ie_type_in,
    output logic                   s1_valid,
    output mem_stage_pkg::opsize_t s1_size,
    output mem_stage_pkg::addr_t   s1_addr1,
    output mem_stage_pkg::addr_t   s1_addr2,
    output mem_stage_pkg::rw_t     s1_rw1,
    output mem_stage_pkg::rw_t     s1_rw2,
    output mem_stage_pkg::lim_t    s1_lim1,
    output mem_stage_pkg::lim_t    s1_lim2,
    output mem_stage_pkg::data_t   s1_reg1,
    output mem_stage_pkg::data_t   s1_reg2,
    output mem_stage_pkg::data_t   s1_imm,
    output mem_stage_pkg::op_sel_t s1_op1_sel,
    output mem_stage_pkg::op_sel_t s1_op2_sel,
    output logic                   s1_ie,
    output mem_stage_pkg::exc_t    s1_ie_type
);

    mem_stage_pkg::opsize_t eff_size;
    mem_stage_pkg::addr_t   push_bytes;
    mem_stage_pkg::addr_t   addr2_adj;
    logic                   load;

    always_comb begin
        case (size_ovr)
            4'b0001: eff_size = 2'd0;
            4'b0010: eff_size = 2'd1;
            4'b0100: eff_size = 2'd2;
            4'b1000: eff_size = 2'd3;
            default: eff_size = opsize; // No override present.
        endcase
    end

    // A push moves the stack address down by the operand size, wrapping.
    assign push_bytes = mem_stage_pkg::addr_t'(1) << eff_size;
    assign addr2_adj  = is_push ? addr2 - push_bytes : addr2;

    assign load  = !s1_valid || s1_ready;
    assign stall = !load;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (load) begin
            s1_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            s1_size    <= eff_size;
            s1_addr1   <= addr1;
            s1_addr2   <= addr2_adj;
            s1_rw1     <= rw1;
            s1_rw2     <= rw2;
            s1_lim1    <= lim1;
            s1_lim2    <= lim2;
            s1_reg1    <= reg1;
            s1_reg2    <= reg2;
            s1_imm     <= imm;
            s1_op1_sel <= op1_sel;
            s1_op2_sel <= op2_sel;
            s1_ie      <= ie_in;
            s1_ie_type <= ie_type_in;
        end
    end

    a_ovr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        valid_in |-> $onehot0(size_ovr));

    // The producer keeps the instruction steady until the stage takes it.
    a_hold_inputs: assert property (@(posedge clk) disable iff (!rst_n)
        valid_in && stall |=> valid_in && $stable({opsize, size_ovr, is_push, addr1, addr2,
            rw1, rw2, lim1, lim2, reg1, reg2, imm, op1_sel, op2_sel, ie_in, ie_type_in}));

endmodule

/* design/mem_seg_check.sv */
`timescale 1ns/100ps
`include "mem_stage_config.svh"

module mem_seg_check (
    input  logic                   s1_valid,
    input  mem_stage_pkg::opsize_t s1_size,
    input  mem_stage_pkg::addr_t   s1_addr1,
    input  mem_stage_pkg::addr_t   s1_addr2,
    input  mem_stage_pkg::rw_t     s1_rw1,
    input  mem_stage_pkg::rw_t     s1_rw2,
    input  mem_stage_pkg::lim_t    s1_lim1,
    input  mem_stage_pkg::lim_t    s1_lim2,
    output logic                   seg_fault
);

    logic [`MEM_ADDR_W:0] nbytes;
    logic                 fault1;
    logic                 fault2;

    // The end address carries one extra bit so a run past the top cannot wrap.
    function automatic logic access_fault(
        input mem_stage_pkg::addr_t addr,
        input mem_stage_pkg::lim_t  lim,
        input mem_stage_pkg::rw_t   rw,
        input logic [`MEM_ADDR_W:0] len
    );
        logic [`MEM_ADDR_W:0] end_addr;
        end_addr = {1'b0, addr} + len - 1'b1;
        return (rw != 2'd0) && (end_addr > lim);
    endfunction

    assign nbytes = (`MEM_ADDR_W+1)'(1) << s1_size;

    assign fault1 = access_fault(s1_addr1, s1_lim1, s1_rw1, nbytes);
    assign fault2 = access_fault(s1_addr2, s1_lim2, s1_rw2, nbytes);

    assign seg_fault = s1_valid && (fault1 || fault2);

endmodule

/* design/mem_data_ram.sv */
`timescale 1ns/100ps
`include "mem_stage_config.svh"

module mem_data_ram (
    input  logic                 clk,
    input  mem_stage_pkg::addr_t rd_addr,
    output mem_stage_pkg::data_t rd_data,
    input  logic                 wb_valid,
    input  mem_stage_pkg::addr_t wb_addr,
    input  mem_stage_pkg::data_t wb_data
);

    mem_stage_pkg::data_t     mem [`MEM_RAM_DEPTH];
    logic [`MEM_RAM_AW-1:0]   rd_idx;
    logic [`MEM_RAM_AW-1:0]   wb_idx;

    // Word addressed, so the byte offset bits drop out.
    assign rd_idx = rd_addr[`MEM_RAM_AW+1:2];
    assign wb_idx = wb_addr[`MEM_RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            mem[wb_idx] <= wb_data;
        end
    end

    assign rd_data = mem[rd_idx]; // Same-cycle write is not forwarded.

endmodule

/* design/mem_operand_sel.sv */
`timescale 1ns/100ps

module mem_operand_sel (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hold,
    input  logic                   s1_valid,
    output logic                   s1_ready,
    input  mem_stage_pkg::data_t   s1_reg1,
    input  mem_stage_pkg::data_t   s1_reg2,
    input  mem_stage_pkg::data_t   s1_imm,
    input  mem_stage_pkg::addr_t   s1_addr2,
    input  mem_stage_pkg::data_t   rd_data,
    input  mem_stage_pkg::op_sel_t s1_op1_sel,
    input  mem_stage_pkg::op_sel_t s1_op2_sel,
    input  logic                   s1_ie,
    input  mem_stage_pkg::exc_t    s1_ie_type,
    input  logic                   seg_fault,
    output logic                   valid_out,
    output mem_stage_pkg::data_t   op1_val,
    output mem_stage_pkg::data_t   op2_val,
    output logic                   ie_out,
    output mem_stage_pkg::exc_t    ie_type_out
);

    mem_stage_pkg::data_t op1_nxt;
    mem_stage_pkg::data_t op2_nxt;
    logic                 ie_nxt;
    mem_stage_pkg::exc_t  ie_type_nxt;

    // The register source differs per slot, the rest is shared.
    function automatic mem_stage_pkg::data_t pick(
        input mem_stage_pkg::op_sel_t sel,
        input mem_stage_pkg::data_t   reg_val,
        input mem_stage_pkg::data_t   mem_val,
        input mem_stage_pkg::data_t   imm_val,
        input mem_stage_pkg::addr_t   addr_val
    );
        case (sel)
            mem_stage_pkg::OP_REG:   return reg_val;
            mem_stage_pkg::OP_MEM:   return mem_val;
            mem_stage_pkg::OP_IMM:   return imm_val;
            default:                 return mem_stage_pkg::data_t'(addr_val);
        endcase
    endfunction

    assign op1_nxt = pick(s1_op1_sel, s1_reg1, rd_data, s1_imm, s1_addr2);
    assign op2_nxt = pick(s1_op2_sel, s1_reg2, rd_data, s1_imm, s1_addr2);

    // A new limit fault joins whatever the instruction already carries.
    assign ie_nxt      = s1_valid && (s1_ie || seg_fault);
    assign ie_type_nxt = {s1_valid && s1_ie_type[1], seg_fault};

    assign s1_ready = !valid_out || !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out   <= 1'b0;
            ie_out      <= 1'b0;
            ie_type_out <= '0;
        end else if (s1_ready) begin
            valid_out   <= s1_valid;
            ie_out      <= ie_nxt;
            ie_type_out <= ie_type_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_ready) begin
            op1_val <= op1_nxt;
            op2_val <= op2_nxt;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && hold |=> valid_out && $stable({op1_val, op2_val, ie_out, ie_type_out}));

endmodule

/* design/mem_stage_top.sv */
`timescale 1ns/100ps

module mem_stage_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_in,
    output logic                   stall,
    input  mem_stage_pkg::opsize_t opsize,
    input  mem_stage_pkg::ovr_t    size_ovr,
    input  logic                   is_push,
    input  mem_stage_pkg::addr_t   addr1,
    input  mem_stage_pkg::addr_t   addr2,
    input  mem_stage_pkg::rw_t     rw1,
    input  mem_stage_pkg::rw_t     rw2,
    input  mem_stage_pkg::lim_t    lim1,
    input  mem_stage_pkg::lim_t    lim2,
    input  mem_stage_pkg::data_t   reg1,
    input  mem_stage_pkg::data_t   reg2,
    input  mem_stage_pkg::data_t   imm,
    input  mem_stage_pkg::op_sel_t op1_sel,
    input  mem_stage_pkg::op_sel_t op2_sel,
    input  logic                   ie_in,
    input  mem_stage_pkg::exc_t    ie_type_in,
    input  logic                   hold,
    output logic                   valid_out,
    output mem_stage_pkg::data_t   op1_val,
    output mem_stage_pkg::data_t   op2_val,
    output logic                   ie_out,
    output mem_stage_pkg::exc_t    ie_type_out,
    input  logic                   wb_valid,
    input  mem_stage_pkg::addr_t   wb_addr,
    input  mem_stage_pkg::data_t   wb_data
);

    logic                   s1_valid;
    logic                   s1_ready;
    mem_stage_pkg::opsize_t s1_size;
    mem_stage_pkg::addr_t   s1_addr1;
    mem_stage_pkg::addr_t   s1_addr2;
    mem_stage_pkg::rw_t     s1_rw1;
    mem_stage_pkg::rw_t     s1_rw2;
    mem_stage_pkg::lim_t    s1_lim1;
    mem_stage_pkg::lim_t    s1_lim2;
    mem_stage_pkg::data_t   s1_reg1;
    mem_stage_pkg::data_t   s1_reg2;
    mem_stage_pkg::data_t   s1_imm;
    mem_stage_pkg::op_sel_t s1_op1_sel;
    mem_stage_pkg::op_sel_t s1_op2_sel;
    logic                   s1_ie;
    mem_stage_pkg::exc_t    s1_ie_type;
    logic                   seg_fault;
    mem_stage_pkg::data_t   rd_data;

    mem_addr_gen i_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .stall      (stall),
        .s1_ready   (s1_ready),
        .opsize     (opsize),
        .size_ovr   (size_ovr),
        .is_push    (is_push),
        .addr1      (addr1),
        .addr2      (addr2),
        .rw1        (rw1),
        .rw2        (rw2),
        .lim1       (lim1),
        .lim2       (lim2),
        .reg1       (reg1),
        .reg2       (reg2),
        .imm        (imm),
        .op1_sel    (op1_sel),
        .op2_sel    (op2_sel),
        .ie_in      (ie_in),
        .ie_type_in (ie_type_in),
        .s1_valid   (s1_valid),
        .s1_size    (s1_size),
        .s1_addr1   (s1_addr1),
        .s1_addr2   (s1_addr2),
        .s1_rw1     (s1_rw1),
        .s1_rw2     (s1_rw2),
        .s1_lim1    (s1_lim1),
        .s1_lim2    (s1_lim2),
        .s1_reg1    (s1_reg1),
        .s1_reg2    (s1_reg2),
        .s1_imm     (s1_imm),
        .s1_op1_sel (s1_op1_sel),
        .s1_op2_sel (s1_op2_sel),
        .s1_ie      (s1_ie),
        .s1_ie_type (s1_ie_type)
    );

    mem_seg_check i_seg_check (
        .s1_valid  (s1_valid),
        .s1_size   (s1_size),
        .s1_addr1  (s1_addr1),
        .s1_addr2  (s1_addr2),
        .s1_rw1    (s1_rw1),
        .s1_rw2    (s1_rw2),
        .s1_lim1   (s1_lim1),
        .s1_lim2   (s1_lim2),
        .seg_fault (seg_fault)
    );

    mem_data_ram i_data_ram (
        .clk      (clk),
        .rd_addr  (s1_addr1),
        .rd_data  (rd_data),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    mem_operand_sel i_operand_sel (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold),
        .s1_valid    (s1_valid),
        .s1_ready    (s1_ready),
        .s1_reg1     (s1_reg1),
        .s1_reg2     (s1_reg2),
        .s1_imm      (s1_imm),
        .s1_addr2    (s1_addr2),
        .rd_data     (rd_data),
        .s1_op1_sel  (s1_op1_sel),
        .s1_op2_sel  (s1_op2_sel),
        .s1_ie       (s1_ie),
        .s1_ie_type  (s1_ie_type),
        .seg_fault   (seg_fault),
        .valid_out   (valid_out),
        .op1_val     (op1_val),
        .op2_val     (op2_val),
        .ie_out      (ie_out),
        .ie_type_out (ie_type_out)
    );

endmodule

/* sim/tb_mem_stage_ref.svh */
`ifndef TB_MEM_STAGE_REF_SVH
`define TB_MEM_STAGE_REF_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// An override bit names the size code directly.
function automatic mem_stage_pkg::opsize_t ref_size(input mem_stage_pkg::opsize_t dec_size,
                                                     input mem_stage_pkg::ovr_t ovr);
    mem_stage_pkg::opsize_t size;
    size = dec_size;
    for (int n = 0; n < 4; n++) begin
        if (ovr[n]) begin
            size = mem_stage_pkg::opsize_t'(n);
        end
    end
    return size;
endfunction

function automatic mem_stage_pkg::addr_t ref_addr2(input mem_stage_pkg::addr_t a,
        input logic push, input mem_stage_pkg::opsize_t size);
    int moved;
    moved = int'(a);
    if (push) begin
        moved = moved - (1 << size); // Wraps below zero like the stack pointer does.
    end
    return mem_stage_pkg::addr_t'(moved);
endfunction

function automatic logic ref_fault(input mem_stage_pkg::addr_t a, input mem_stage_pkg::lim_t lim,
        input mem_stage_pkg::rw_t rw, input mem_stage_pkg::opsize_t size);
    int last;
    last = int'(a) + (1 << size) - 1;
    return (rw != 2'd0) && (last > int'(lim));
endfunction

function automatic mem_stage_pkg::data_t ref_operand(input mem_stage_pkg::op_sel_t sel,
        input mem_stage_pkg::data_t reg_val, input mem_stage_pkg::addr_t addr2_adj);
    case (sel)
        mem_stage_pkg::OP_REG: return reg_val;
        mem_stage_pkg::OP_MEM: return ram_copy[addr1[`MEM_RAM_AW+1:2]];
        mem_stage_pkg::OP_IMM: return imm;
        default:               return {{(`MEM_DATA_W-`MEM_ADDR_W){1'b0}}, addr2_adj};
    endcase
endfunction

// Expected stage output for the instruction now on the input ports.
function automatic out_t expect_now();
    mem_stage_pkg::opsize_t size;
    mem_stage_pkg::addr_t   a2;
    logic                   fault;
    out_t                   res;
    size        = ref_size(opsize, size_ovr);
    a2          = ref_addr2(addr2, is_push, size);
    fault       = ref_fault(addr1, lim1, rw1, size) || ref_fault(a2, lim2, rw2, size);
    res.valid   = 1'b1;
    res.op1     = ref_operand(op1_sel, reg1, a2);
    res.op2     = ref_operand(op2_sel, reg2, a2);
    res.ie      = ie_in || fault;
    res.ie_type = {ie_type_in[1], fault};
    return res;
endfunction

`endif

/* sim/tb_mem_stage.sv */
`timescale 1ns/100ps
`include "mem_stage_config.svh"

module tb_mem_stage;

    localparam int WAIT_LIMIT = 400;
    localparam int STREAM_LEN = 200;

    typedef struct packed {
        logic                 valid;
        mem_stage_pkg::data_t op1;
        mem_stage_pkg::data_t op2;
        logic                 ie;
        mem_stage_pkg::exc_t  ie_type;
    } out_t;

    logic                   clk;
    logic                   rst_n;
    logic                   valid_in;
    logic                   stall;
    mem_stage_pkg::opsize_t opsize;
    mem_stage_pkg::ovr_t    size_ovr;
    logic                   is_push;
    mem_stage_pkg::addr_t   addr1;
    mem_stage_pkg::addr_t   addr2;
    mem_stage_pkg::rw_t     rw1;
    mem_stage_pkg::rw_t     rw2;
    mem_stage_pkg::lim_t    lim1;
    mem_stage_pkg::lim_t    lim2;
    mem_stage_pkg::data_t   reg1;
    mem_stage_pkg::data_t   reg2;
    mem_stage_pkg::data_t   imm;
    mem_stage_pkg::op_sel_t op1_sel;
    mem_stage_pkg::op_sel_t op2_sel;
    logic                   ie_in;
    mem_stage_pkg::exc_t    ie_type_in;
    logic                   hold;
    logic                   valid_out;
    mem_stage_pkg::data_t   op1_val;
    mem_stage_pkg::data_t   op2_val;
    logic                   ie_out;
    mem_stage_pkg::exc_t    ie_type_out;
    logic                   wb_valid;
    mem_stage_pkg::addr_t   wb_addr;
    mem_stage_pkg::data_t   wb_data;

    mem_stage_pkg::data_t   ram_copy [`MEM_RAM_DEPTH]; // What the data RAM should hold.
    logic [31:0]            rng_state;
    logic                   hold_random;
    out_t                   exp_q [$];

    `include "tb_mem_stage_ref.svh"

    mem_stage_top i_dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] want);
        if (got !== want) begin
            fail_stop($sformatf("Fail at time %0t: %s, got %0h, expected %0h",
                                $time, what, got, want));
        end
    endtask

    // Every input changes here, half a period away from the sampling edge.
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        r    = hold_random ? rand32() : 32'd0;
        hold = (r % 5) >= 3;
    endtask

    task automatic randomize_inputs();
        logic [31:0] r;
        r          = rand32();
        opsize     = r[1:0];
        size_ovr   = r[2] ? (4'b0001 << r[4:3]) : 4'b0000;
        is_push    = r[5];
        rw1        = r[7:6];
        rw2        = r[9:8];
        op1_sel    = mem_stage_pkg::op_sel_t'(r[11:10]);
        op2_sel    = mem_stage_pkg::op_sel_t'(r[13:12]);
        ie_in      = r[14];
        ie_type_in = r[16:15];
        r          = rand32();
        addr1      = r[15:0];
        addr2      = r[31:16];
        r          = rand32();
        // Limits mostly sit a few bytes above the address so both outcomes occur.
        lim1       = r[0] ? r[31:16] : addr1 + {13'd0, r[3:1]};
        lim2       = r[4] ? r[31:16] : addr2 + {13'd0, r[7:5]};
        reg1       = rand32();
        reg2       = rand32();
        imm        = rand32();
    endtask

    task automatic issue();
        out_t want;
        int   waited;
        waited   = 0;
        valid_in = 1'b1;
        #1;
        while (stall) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_stop("Timeout while waiting for the stage to take an instruction.");
            end
            next_cycle();
            #1;
        end
        want = expect_now(); // Taken at the coming edge.
        next_cycle();
        exp_q.push_back(want);
        valid_in = 1'b0;
    endtask

    task automatic write_word(input int idx);
        logic [31:0] r;
        r             = rand32();
        wb_valid      = 1'b1;
        wb_addr       = {r[7:0], idx[`MEM_RAM_AW-1:0], r[9:8]};
        wb_data       = rand32();
        ram_copy[idx] = wb_data;
        next_cycle();
        wb_valid      = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_stop("Timeout while waiting for the expected outputs to come out.");
            end
        end while (exp_q.size() != 0);
    endtask

    // Outputs are looked at mid-cycle, where they are stable.
    initial begin : compare_outputs
        out_t seen;
        out_t last;
        out_t want;
        logic was_held;
        was_held = 1'b0;
        last     = '0;
        forever begin
            @(negedge clk);
            #1;
            seen = {valid_out, op1_val, op2_val, ie_out, ie_type_out};
            if (was_held) begin
                check_value("output stable under hold", 128'(seen), 128'(last));
            end
            if (valid_out === 1'b1 && hold === 1'b0) begin
                if (exp_q.size() == 0) begin
                    fail_stop("An output was consumed with no instruction waiting for it.");
                end else begin
                    want = exp_q.pop_front();
                    check_value("consumed output", 128'(seen), 128'(want));
                end
            end
            was_held = (valid_out === 1'b1) && (hold === 1'b1);
            last     = seen;
        end
    end

    initial begin : run_tests
        int          i;
        int          s;
        int          d;
        int          k;
        logic [31:0] r;
        rng_state   = 32'd17;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        hold        = 1'b0;
        hold_random = 1'b0;
        wb_valid    = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        randomize_inputs();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("valid_out, stall and ie_out after reset",
                    128'({valid_out, stall, ie_out}), 128'(0));

        // A lone instruction, register and immediate only while the RAM is unwritten.
        next_cycle();
        randomize_inputs();
        op1_sel = mem_stage_pkg::OP_REG;
        op2_sel = mem_stage_pkg::OP_IMM;
        issue();
        #1;
        check_value("valid_out one cycle after acceptance", 128'(valid_out), 128'(0));
        next_cycle();
        #1;
        check_value("valid_out two cycles after acceptance", 128'(valid_out), 128'(1));
        wait_drain();

        for (i = 0; i < `MEM_RAM_DEPTH; i++) begin
            write_word(i);
        end

        for (i = 0; i < 40; i++) begin
            randomize_inputs();
            op1_sel = mem_stage_pkg::OP_ADDR2;
            issue();
        end
        wait_drain();

        for (i = 0; i < `MEM_RAM_DEPTH; i++) begin
            randomize_inputs();
            op1_sel = mem_stage_pkg::OP_MEM;
            addr1[`MEM_RAM_AW+1:2] = i[`MEM_RAM_AW-1:0];
            issue();
        end
        wait_drain();

        for (s = 0; s < 4; s++) begin
            for (d = 0; d < 2; d++) begin
                for (k = 0; k < 6; k++) begin
                    randomize_inputs();
                    opsize   = mem_stage_pkg::opsize_t'(s);
                    size_ovr = '0;
                    is_push  = 1'b0;
                    rw1      = '0;
                    rw2      = '0;
                    // The access ends on its limit, or one byte past it when d is set.
                    if (k[0]) begin
                        addr2 = mem_stage_pkg::addr_t'(int'(lim2) - (1 << s) + 1 + d);
                        rw2   = mem_stage_pkg::rw_t'(k / 2);
                    end else begin
                        addr1 = mem_stage_pkg::addr_t'(int'(lim1) - (1 << s) + 1 + d);
                        rw1   = mem_stage_pkg::rw_t'(k / 2);
                    end
                    issue();
                end
            end
        end
        wait_drain();

        hold_random = 1'b1;
        for (i = 0; i < STREAM_LEN; i++) begin
            randomize_inputs();
            issue();
            r = rand32();
            if (r[1:0] == 2'd0) begin
                next_cycle(); // Leave a gap in the stream.
            end
        end
        wait_drain();
        hold_random = 1'b0;
        repeat (4) next_cycle();

        if (valid_out !== 1'b0 || stall !== 1'b0) begin
            fail_stop("The stage did not go idle after the last instruction.");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* mem_stage.f */
+incdir+design
+incdir+sim
design/mem_stage_pkg.sv
design/mem_addr_gen.sv
design/mem_seg_check.sv
design/mem_data_ram.sv
design/mem_operand_sel.sv
design/mem_stage_top.sv
sim/tb_mem_stage.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP      = tb_mem_stage
FILELIST = mem_stage.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
